//--- logic/cf_pkg.sv
`default_nettype none

package cf_pkg;

   // ============================================================
   // sizes
   // ============================================================
   localparam int num_slots   = 2;
   localparam int instr_w     = 32;
   localparam int addr_w      = 32;
   localparam int reg_addr_w  = 5;
   localparam int queue_depth = 4;
   localparam int ptr_w       = 3;   // 2 index bits plus wrap bit
   localparam int wb_delay    = 2;   // commit to register-file write

   typedef logic [instr_w-1:0]    instr_t;
   typedef logic [addr_w-1:0]     addr_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;
   typedef logic [2:0]            isize_t;   // 2 or 4 bytes

   // original control-flow instruction waiting for its duplicate
   typedef struct packed {
      instr_t instr;
      addr_t  pc;
      addr_t  next_pc;
      logic   next_pc_valid;   // low until the successor commits
      logic   taken;
      isize_t isize;
   } cf_entry_t;

   // pending link-register write check
   typedef struct packed {
      logic      check;
      reg_addr_t rd;
      addr_t     link;   // pc plus instruction size
   } link_job_t;

   // ============================================================
   // decode helpers
   // ============================================================
   function automatic logic is_branch(input instr_t instr);
      return instr[6:0] == 7'b1100011;
   endfunction

   function automatic logic is_jal(input instr_t instr);
      return instr[6:0] == 7'b1101111;
   endfunction

   function automatic logic is_jalr(input instr_t instr);
      return instr[6:0] == 7'b1100111;
   endfunction

   function automatic logic is_cf(input instr_t instr);
      return is_branch(instr) || is_jal(instr) || is_jalr(instr);
   endfunction

   function automatic reg_addr_t get_rd(input instr_t instr);
      return instr[11:7];
   endfunction

   // distance from pc to destination, fall-through branches net out to zero
   function automatic addr_t dest_offset(input addr_t  pc,
                                         input addr_t  dest,
                                         input instr_t instr,
                                         input logic   taken,
                                         input isize_t isize);
      addr_t offset;
      offset = dest - pc;
      if (is_branch(instr) && !taken)
         offset = offset - addr_t'(isize);
      return offset;
   endfunction

endpackage

`default_nettype wire

//--- logic/cf_event_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cf_event_if import cf_pkg::*; ();

   logic   push_orig;        // original cf instruction committed
   logic   save_dup;         // duplicate cf instruction committed
   logic   any_commit;
   instr_t instr;
   addr_t  pc;
   isize_t isize;
   logic   taken;
   addr_t  same_next_pc;     // pc of the slot after the cf slot
   logic   same_next_valid;
   addr_t  first_pc;         // slot 1 pc

   modport sel (output push_orig, save_dup, any_commit, instr, pc, isize, taken,
                       same_next_pc, same_next_valid, first_pc);

   modport queue (input push_orig, any_commit, instr, pc, isize, taken,
                        same_next_pc, same_next_valid, first_pc);

   modport dup (input save_dup, any_commit, instr, pc, isize, taken, first_pc);

   modport link (input push_orig, save_dup, instr, pc, isize);

endinterface

`default_nettype wire

//--- logic/cf_commit_select.sv
`timescale 1ns/1ns
`default_nettype none

module cf_commit_select import cf_pkg::*; (
   input  logic                 cf_enable,
   input  logic   [num_slots:1] commit,
   input  instr_t [num_slots:1] slot_instr,
   input  addr_t  [num_slots:1] slot_pc,
   input  isize_t [num_slots:1] slot_isize,
   input  logic   [num_slots:1] slot_taken,
   input  logic   [num_slots:1] slot_is_dup,
   input  logic   [num_slots:1] slot_received_kill,
   input  logic                 dut_branch_taken,
   cf_event_if.sel              ev
);

   int   sel;      // slot of the selected cf instruction
   logic found;
   logic is_dup;

   // scan from the top so the lowest slot wins
   always_comb begin
      sel   = 1;
      found = 1'b0;
      for (int i = num_slots; i >= 1; i--) begin
         if (commit[i] && is_cf(slot_instr[i])) begin
            sel   = i;
            found = 1'b1;
         end
      end
   end

   assign is_dup = slot_is_dup[sel];

   assign ev.any_commit = |commit;
   assign ev.push_orig  = cf_enable && found && !is_dup;
   assign ev.save_dup   = cf_enable && found && is_dup;
   assign ev.instr      = slot_instr[sel];
   assign ev.pc         = slot_pc[sel];
   assign ev.isize      = slot_isize[sel];
   assign ev.first_pc   = slot_pc[1];

   // original keeps the prediction, duplicate reports the resolved outcome
   assign ev.taken = is_dup ? (dut_branch_taken || slot_received_kill[sel])
                            : slot_taken[sel];

   // successor committing alongside gives the next pc right away
   always_comb begin
      ev.same_next_valid = 1'b0;
      ev.same_next_pc    = '0;
      for (int i = 1; i < num_slots; i++) begin
         if (found && sel == i && commit[i+1]) begin
            ev.same_next_valid = 1'b1;
            ev.same_next_pc    = slot_pc[i+1];
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/cf_orig_queue.sv
`timescale 1ns/1ns
`default_nettype none

module cf_orig_queue import cf_pkg::*; (
   input  logic      clk,
   input  logic      reset_,
   cf_event_if.queue ev,
   input  logic      pop,
   output cf_entry_t head,
   output logic      empty
);

   cf_entry_t        mem [queue_depth];
   cf_entry_t        new_entry;
   logic [ptr_w-1:0] head_ptr;
   logic [ptr_w-1:0] tail_ptr;
   logic [ptr_w-1:0] newest_ptr;   // last pushed entry
   logic             patch;

   assign empty      = head_ptr == tail_ptr;
   assign head       = mem[head_ptr[ptr_w-2:0]];
   assign newest_ptr = tail_ptr - 1'b1;

   // ============================================================
   // entry write and late next-pc capture
   // ============================================================
   assign new_entry.instr         = ev.instr;
   assign new_entry.pc            = ev.pc;
   assign new_entry.next_pc       = ev.same_next_pc;
   assign new_entry.next_pc_valid = ev.same_next_valid;
   assign new_entry.taken         = ev.taken;
   assign new_entry.isize         = ev.isize;

   // first commit after a lone original carries its successor in slot 1
   assign patch = ev.any_commit && !empty &&
                  !mem[newest_ptr[ptr_w-2:0]].next_pc_valid;

   always_ff @(posedge clk) begin
      if (ev.push_orig)
         mem[tail_ptr[ptr_w-2:0]] <= new_entry;
      if (patch) begin   // never the tail slot, so no clash with the push
         mem[newest_ptr[ptr_w-2:0]].next_pc       <= ev.first_pc;
         mem[newest_ptr[ptr_w-2:0]].next_pc_valid <= 1'b1;
      end
   end

   // ============================================================
   // pointers
   // ============================================================
   always_ff @(posedge clk) begin
      if (!reset_) begin
         tail_ptr <= '0;
      end else if (ev.push_orig) begin
         tail_ptr <= tail_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_) begin
         head_ptr <= '0;
      end else if (pop) begin   // compare done for the head
         head_ptr <= head_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- logic/cf_dup_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cf_dup_fsm import cf_pkg::*; (
   input  logic      clk,
   input  logic      reset_,
   cf_event_if.dup   ev,
   input  cf_entry_t head,
   input  logic      empty,
   output logic      pop,
   output logic      check_done,
   output logic      err_cf_dest,
   output logic      err_no_orig
);

   typedef enum logic {st_idle, st_held} state_t;

   state_t state;
   instr_t dup_instr;
   addr_t  dup_pc;
   isize_t dup_isize;
   logic   dup_taken;
   logic   compare;
   logic   mismatch;
   addr_t  orig_offset;
   addr_t  dup_offset;

   // ============================================================
   // compare against the queue head
   // ============================================================
   assign compare = (state == st_held) && ev.any_commit;
   assign pop     = compare && !empty;

   assign orig_offset = dest_offset(head.pc, head.next_pc, head.instr, head.taken,
                                    head.isize);
   // duplicate's destination is whatever commits first after it
   assign dup_offset  = dest_offset(dup_pc, ev.first_pc, dup_instr, dup_taken,
                                    dup_isize);

   assign mismatch = (orig_offset != dup_offset) ||
                     (head.instr != dup_instr) ||
                     (is_branch(dup_instr) && (head.taken != dup_taken));

   // ============================================================
   // state and duplicate record
   // ============================================================
   always_ff @(posedge clk) begin
      if (!reset_) begin
         state <= st_idle;
      end else if (ev.save_dup) begin   // new duplicate wins over the clear
         state <= st_held;
      end else if (compare) begin
         state <= st_idle;
      end
   end

   // old record is read by the compare before it is replaced
   always_ff @(posedge clk) begin
      if (ev.save_dup) begin
         dup_instr <= ev.instr;
         dup_pc    <= ev.pc;
         dup_isize <= ev.isize;
         dup_taken <= ev.taken;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_) begin
         check_done  <= 1'b0;
         err_cf_dest <= 1'b0;
         err_no_orig <= 1'b0;
      end else begin
         check_done  <= compare;
         err_cf_dest <= compare && !empty && mismatch;
         err_no_orig <= compare && empty;   // duplicate with no original
      end
   end

endmodule

`default_nettype wire

//--- logic/cf_link_timer.sv
`timescale 1ns/1ns
`default_nettype none

module cf_link_timer import cf_pkg::*; (
   input  logic      clk,
   input  logic      reset_,
   cf_event_if.link  ev,
   input  logic      rf_write_en,
   input  reg_addr_t rf_write_rd,
   input  addr_t     rf_write_data,
   output logic      rf_lock,
   output logic      rf_unlock,
   output logic      err_link
);

   link_job_t pipe [wb_delay];
   link_job_t new_job;
   link_job_t out_job;   // job whose write is due this cycle
   reg_addr_t new_rd;

   assign new_rd        = get_rd(ev.instr);
   assign new_job.check = (ev.push_orig || ev.save_dup) &&
                          (is_jal(ev.instr) || is_jalr(ev.instr)) &&
                          (new_rd != '0);   // x0 writes are dropped
   assign new_job.rd    = new_rd;
   assign new_job.link  = ev.pc + addr_t'(ev.isize);

   always_ff @(posedge clk) begin
      if (!reset_) begin
         for (int i = 0; i < wb_delay; i++)
            pipe[i] <= '0;
      end else begin
         pipe[0] <= new_job;
         for (int i = 1; i < wb_delay; i++)
            pipe[i] <= pipe[i-1];
      end
   end

   assign out_job = pipe[wb_delay-1];

   // hold the link write back from the register file
   assign rf_lock   = out_job.check && rf_write_en && (rf_write_rd != '0);
   assign rf_unlock = rf_write_en && !rf_lock;

   // missing write, wrong register or wrong link value
   always_ff @(posedge clk) begin
      if (!reset_) begin
         err_link <= 1'b0;
      end else begin
         err_link <= out_job.check &&
                     (!rf_write_en || (rf_write_rd != out_job.rd) ||
                      (rf_write_data != out_job.link));
      end
   end

endmodule

`default_nettype wire

//--- logic/cf_checker_top.sv
`timescale 1ns/1ns
`default_nettype none

module cf_checker_top import cf_pkg::*; (
   input  logic                 clk,
   input  logic                 reset_,
   input  logic                 cf_enable,
   input  logic   [num_slots:1] commit,
   input  instr_t [num_slots:1] slot_instr,
   input  addr_t  [num_slots:1] slot_pc,
   input  isize_t [num_slots:1] slot_isize,
   input  logic   [num_slots:1] slot_taken,          // predicted
   input  logic   [num_slots:1] slot_is_dup,
   input  logic   [num_slots:1] slot_received_kill,
   input  logic                 dut_branch_taken,
   input  logic                 rf_write_en,
   input  reg_addr_t            rf_write_rd,
   input  addr_t                rf_write_data,
   output logic                 rf_lock,
   output logic                 rf_unlock,
   output logic                 check_done,
   output logic                 err_cf_dest,
   output logic                 err_no_orig,
   output logic                 err_link
);

   cf_entry_t queue_head;
   logic      queue_empty;
   logic      queue_pop;

   cf_event_if ev ();

   cf_commit_select u_select (
      .cf_enable          (cf_enable),
      .commit             (commit),
      .slot_instr         (slot_instr),
      .slot_pc            (slot_pc),
      .slot_isize         (slot_isize),
      .slot_taken         (slot_taken),
      .slot_is_dup        (slot_is_dup),
      .slot_received_kill (slot_received_kill),
      .dut_branch_taken   (dut_branch_taken),
      .ev                 (ev.sel)
   );

   cf_orig_queue u_queue (
      .clk    (clk),
      .reset_ (reset_),
      .ev     (ev.queue),
      .pop    (queue_pop),
      .head   (queue_head),
      .empty  (queue_empty)
   );

   cf_dup_fsm u_dup (
      .clk         (clk),
      .reset_      (reset_),
      .ev          (ev.dup),
      .head        (queue_head),
      .empty       (queue_empty),
      .pop         (queue_pop),
      .check_done  (check_done),
      .err_cf_dest (err_cf_dest),
      .err_no_orig (err_no_orig)
   );

   cf_link_timer u_link (
      .clk           (clk),
      .reset_        (reset_),
      .ev            (ev.link),
      .rf_write_en   (rf_write_en),
      .rf_write_rd   (rf_write_rd),
      .rf_write_data (rf_write_data),
      .rf_lock       (rf_lock),
      .rf_unlock     (rf_unlock),
      .err_link      (err_link)
   );

endmodule

`default_nettype wire

//--- dv/cf_checks.svh
`ifndef CF_CHECKS_SVH
`define CF_CHECKS_SVH

// ============================================================
// compare tasks
// ============================================================

// one flag bit such as a lock, done or error pulse
task automatic check_bit(input string name, input logic got, input logic expected);
   if (got !== expected) begin
      $display("CHECK FAILED %s got %h expected %h at stimulus line %0d",
               name, got, expected, cur_line);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
   end
endtask

`endif

//--- dv/cf_checker_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cf_checker_tb import cf_pkg::*; ();

   localparam int clk_period = 100;
   localparam int num_cols   = 21;   // 15 inputs then 6 expected outputs

   typedef logic [num_cols-1:0][31:0] row_t;

   logic                 clk;
   logic                 reset_;
   logic                 cf_enable;
   logic   [num_slots:1] commit;
   instr_t [num_slots:1] slot_instr;
   addr_t  [num_slots:1] slot_pc;
   isize_t [num_slots:1] slot_isize;
   logic   [num_slots:1] slot_taken;
   logic   [num_slots:1] slot_is_dup;
   logic   [num_slots:1] slot_received_kill;
   logic                 dut_branch_taken;
   logic                 rf_write_en;
   reg_addr_t            rf_write_rd;
   addr_t                rf_write_data;
   logic                 rf_lock;
   logic                 rf_unlock;
   logic                 check_done;
   logic                 err_cf_dest;
   logic                 err_no_orig;
   logic                 err_link;

   row_t rows [$];
   int   row_line [$];        // file line of each row, for error messages
   int   cur_line     = 0;
   int   limit_cycles = 0;
   int   cycle_count  = 0;

   cf_checker_top DUT (
      .clk                (clk),
      .reset_             (reset_),
      .cf_enable          (cf_enable),
      .commit             (commit),
      .slot_instr         (slot_instr),
      .slot_pc            (slot_pc),
      .slot_isize         (slot_isize),
      .slot_taken         (slot_taken),
      .slot_is_dup        (slot_is_dup),
      .slot_received_kill (slot_received_kill),
      .dut_branch_taken   (dut_branch_taken),
      .rf_write_en        (rf_write_en),
      .rf_write_rd        (rf_write_rd),
      .rf_write_data      (rf_write_data),
      .rf_lock            (rf_lock),
      .rf_unlock          (rf_unlock),
      .check_done         (check_done),
      .err_cf_dest        (err_cf_dest),
      .err_no_orig        (err_no_orig),
      .err_link           (err_link)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period/2) clk = ~clk;
   end

   // watchdog, limit is set once the stimulus length is known
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (limit_cycles > 0 && cycle_count >= limit_cycles) begin
         $display("timeout: stimulus did not finish within %0d cycles", limit_cycles);
         $display("test failed");
         $fatal(1, "watchdog expired");
      end
   end

   // ============================================================
   // stimulus file
   // ============================================================
   task automatic load_stimulus();
      int          fd;
      int          line_no;
      int          n;
      string       line;
      logic [31:0] col [num_cols];
      row_t        row;
      fd = $fopen("dv/cf_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open stimulus file dv/cf_stimulus.txt");
         $display("test failed");
         $fatal(1, "no stimulus");
      end
      line_no = 0;
      while ($fgets(line, fd) > 0) begin
         line_no++;
         if (line.len() < 2 || line.getc(0) == "#")   // blank or column notes
            continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                     col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                     col[15], col[16], col[17], col[18], col[19], col[20]);
         if (n != num_cols) begin
            $display("stimulus line %0d is malformed: %0d of %0d fields read",
                     line_no, n, num_cols);
            $display("test failed");
            $fatal(1, "bad stimulus line");
         end
         for (int k = 0; k < num_cols; k++)
            row[k] = col[k];
         rows.push_back(row);
         row_line.push_back(line_no);
      end
      $fclose(fd);
   endtask

   task automatic drive_row(input row_t row);
      cf_enable          = row[0][0];
      commit             = row[1][1:0];   // bit 0 is slot 1
      slot_instr[1]      = row[2];
      slot_instr[2]      = row[3];
      slot_pc[1]         = row[4];
      slot_pc[2]         = row[5];
      slot_isize[1]      = row[6][2:0];
      slot_isize[2]      = row[7][2:0];
      slot_taken         = row[8][1:0];
      slot_is_dup        = row[9][1:0];
      slot_received_kill = row[10][1:0];
      dut_branch_taken   = row[11][0];
      rf_write_en        = row[12][0];
      rf_write_rd        = row[13][4:0];
      rf_write_data      = row[14];
   endtask

   task automatic check_outputs(input row_t row);
      check_bit("rf_lock", rf_lock, row[15][0]);
      check_bit("rf_unlock", rf_unlock, row[16][0]);
      check_bit("check_done", check_done, row[17][0]);
      check_bit("err_cf_dest", err_cf_dest, row[18][0]);
      check_bit("err_no_orig", err_no_orig, row[19][0]);
      check_bit("err_link", err_link, row[20][0]);
   endtask

   // ============================================================
   // main sequence
   // ============================================================
   initial begin
      reset_ = 1'b0;
      drive_row('0);
      load_stimulus();
      if (rows.size() == 0) begin
         $display("stimulus file holds no data lines");
         $display("test failed");
         $fatal(1, "empty stimulus");
      end
      limit_cycles = rows.size() + 20;
      repeat (3) @(posedge clk);
      #1 reset_ = 1'b1;
      foreach (rows[i]) begin
         cur_line = row_line[i];
         @(posedge clk);
         #1 drive_row(rows[i]);
         #(clk_period - 2) check_outputs(rows[i]);   // just before the next edge
      end
      @(posedge clk);
      #1 drive_row('0);
      $display("test passed");
      $finish;
   end

`include "cf_checks.svh"

endmodule

`default_nettype wire

//--- dv/cf_stimulus.txt
# en commit instr1 instr2 pc1 pc2 isize1 isize2 taken dup kill br_taken wr_en wr_rd wr_data
# then expected lock unlock check_done err_cf_dest err_no_orig err_link (masks: bit 0 = slot 1)
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 3 00208463 00000013 00000100 00000140 4 4 1 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00208463 00000013 00000200 00000000 4 4 0 1 1 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000240 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 1 0 0 0
1 1 00208463 00000013 00000300 00000000 2 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000302 00000000 2 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00208463 00000013 00000500 00000000 2 4 0 1 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000502 00000000 2 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 1 0 0 0
1 3 00208463 00000013 00000600 00000620 4 4 1 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00208463 00000013 00000700 00000000 4 4 0 1 0 1 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000740 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 1 1 0 0
1 3 00208463 00000013 00000800 00000804 4 4 1 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00208463 00000013 00000900 00000000 4 4 0 1 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000908 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 1 1 0 0
1 3 010000ef 00000013 00000a00 00000a10 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 010000ef 00000013 00000b00 00000000 4 4 0 1 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000b10 00000000 4 4 0 0 0 0 1 01 00000a04 1 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 1 01 00000b04 1 0 1 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 3 010000ef 00000013 00000c00 00000c20 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 010000ef 00000013 00000d00 00000000 4 4 0 1 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000d20 00000000 4 4 0 0 0 0 1 01 00000c04 1 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 1 01 00000bad 1 0 1 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 1
1 3 0100006f 00000013 00000e00 00000e10 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 0100006f 00000013 00000f00 00000000 4 4 0 1 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00000f10 00000000 4 4 0 0 0 0 1 05 00001234 0 1 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 1 02 00000055 0 1 1 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 1 00208463 00000013 00001000 00000000 4 4 0 1 0 1 0 00 00000000 0 0 0 0 0 0
1 1 00000013 00000013 00001040 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 1 0 1 0
1 0 00000013 00000013 00000000 00000000 4 4 0 0 0 0 0 00 00000000 0 0 0 0 0 0

//--- vlog.f
+incdir+dv
logic/cf_pkg.sv
logic/cf_event_if.sv
logic/cf_commit_select.sv
logic/cf_orig_queue.sv
logic/cf_dup_fsm.sv
logic/cf_link_timer.sv
logic/cf_checker_top.sv
dv/cf_checker_tb.sv

//--- run.sh
#!/bin/sh
# build and run the control-flow checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cf_checker_tb -f vlog.f
./obj_dir/Vcf_checker_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   exit 1
fi
